/* src/fm_pkg.sv */
// Constants and types for a YM2151 style register map without CSM or test registers
package fm_pkg;

    // Plain vectors with a meaning of their own
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [4:0] slot_t;     // {operator, channel}
    typedef logic [2:0] ch_t;
    typedef logic [1:0] op_t;
    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;

    localparam int NUM_SLOTS     = 32;
    localparam int NUM_CH        = 8;
    localparam int BUSY_TICKS    = 32;  // cen ticks per data write
    localparam int TIMER_B_DIV   = 16;  // cen ticks per timer B count
    localparam int BUSY_CNT_W    = $clog2(BUSY_TICKS);
    localparam int TIMER_B_PRE_W = $clog2(TIMER_B_DIV);

    // Global register addresses
    localparam reg_addr_t REG_KON    = 8'h08;
    localparam reg_addr_t REG_NOISE  = 8'h0F;
    localparam reg_addr_t REG_CLKA1  = 8'h10;
    localparam reg_addr_t REG_CLKA2  = 8'h11;
    localparam reg_addr_t REG_CLKB   = 8'h12;
    localparam reg_addr_t REG_TIMER  = 8'h14;
    localparam reg_addr_t REG_LFRQ   = 8'h18;
    localparam reg_addr_t REG_PMDAMD = 8'h19;
    localparam reg_addr_t REG_CTW    = 8'h1B;
    localparam reg_addr_t CH_BANK    = 8'h20; // First channel register
    localparam reg_addr_t OP_BANK    = 8'h40; // First operator register

    typedef struct packed {
        logic rl_fb_con;
        logic kc;
        logic kf;
        logic pms_ams;
        logic dt1_mul;
        logic tl;
        logic ks_ar;
        logic ams_d1r;
        logic dt2_d2r;
        logic d1l_rr;
        logic keyon;
    } upd_strb_t;

    // What to write where
    typedef struct packed {
        upd_strb_t strb;
        slot_t     slot;
        reg_data_t data;
    } upd_t;

    typedef struct packed {
        logic       ne;
        logic [4:0] nfrq;
        logic [7:0] lfo_freq;
        logic [1:0] lfo_w;
        logic [6:0] lfo_amd;
        logic [6:0] lfo_pmd;
        logic       ct1;
        logic       ct2;
    } global_cfg_t;

    typedef struct packed {
        timer_a_t value_a;
        timer_b_t value_b;
        logic     load_a;     // Pulse
        logic     load_b;     // Pulse
        logic     irq_en_a;
        logic     irq_en_b;
        logic     clr_flag_a; // Pulse
        logic     clr_flag_b; // Pulse
    } timer_ctl_t;

    typedef struct packed {
        logic [1:0] rl;
        logic [2:0] fb;
        logic [2:0] con;
        logic [6:0] kc;
        logic [5:0] kf;
        logic [2:0] pms;
        logic [1:0] ams;
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic       amsen;
        logic [4:0] d1r;
        logic [1:0] dt2;
        logic [4:0] d2r;
        logic [3:0] d1l;
        logic [3:0] rr;
        logic       keyon;
    } slot_params_t;

endpackage

/* src/fm_mmr.sv */
// Writes made while busy is high are accepted unchecked and lfo_rst pulses on each LFO rate write
`timescale 1ns/1ns

module fm_mmr (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  fm_pkg::reg_data_t   din,
    input  logic                write,
    input  logic                a0,
    output logic                busy,
    output fm_pkg::upd_t        upd,
    output fm_pkg::global_cfg_t gcfg,
    output fm_pkg::timer_ctl_t  tctl,
    output logic                lfo_rst
);
    import fm_pkg::*;

    reg_addr_t             sel_addr;  // Set by writes with a0 low
    logic                  data_wr;
    logic                  data_wr_q;
    logic [BUSY_CNT_W-1:0] busy_cnt;

    assign data_wr = write & a0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_addr <= '0;
            upd      <= '0;
            gcfg     <= '0;
            tctl     <= '0;
            lfo_rst  <= 1'b0;
        end else begin
            // One-shot outputs drop unless renewed below
            upd.strb        <= '0;
            tctl.load_a     <= 1'b0;
            tctl.load_b     <= 1'b0;
            tctl.clr_flag_a <= 1'b0;
            tctl.clr_flag_b <= 1'b0;
            lfo_rst         <= 1'b0;

            if (write && !a0) begin
                sel_addr <= din;
            end

            if (data_wr) begin
                upd.data <= din;
                if (sel_addr < CH_BANK) begin
                    // Only key-on uses the slot here, channel taken from din
                    upd.slot <= {2'b00, din[2:0]};
                    case (sel_addr)
                        REG_KON:   upd.strb.keyon <= 1'b1;
                        REG_NOISE: begin
                            gcfg.ne   <= din[7];
                            gcfg.nfrq <= din[4:0];
                        end
                        REG_CLKA1: tctl.value_a[9:2] <= din;
                        REG_CLKA2: tctl.value_a[1:0] <= din[1:0];
                        REG_CLKB:  tctl.value_b      <= din;
                        REG_TIMER: begin
                            tctl.load_a     <= din[0];
                            tctl.load_b     <= din[1];
                            tctl.irq_en_a   <= din[2];
                            tctl.irq_en_b   <= din[3];
                            tctl.clr_flag_a <= din[4];
                            tctl.clr_flag_b <= din[5];
                        end
                        REG_LFRQ: begin
                            gcfg.lfo_freq <= din;
                            lfo_rst       <= 1'b1; // Restart LFO phase
                        end
                        REG_PMDAMD: begin
                            if (!din[7]) begin
                                gcfg.lfo_amd <= din[6:0];
                            end else begin
                                gcfg.lfo_pmd <= din[6:0];
                            end
                        end
                        REG_CTW: begin
                            gcfg.ct2   <= din[7];
                            gcfg.ct1   <= din[6];
                            gcfg.lfo_w <= din[1:0];
                        end
                        default: ;
                    endcase
                end else if (sel_addr < OP_BANK) begin
                    // Channel bank, field in bits 4:3
                    upd.slot <= {2'b00, sel_addr[2:0]};
                    case (sel_addr[4:3])
                        2'd0:    upd.strb.rl_fb_con <= 1'b1;
                        2'd1:    upd.strb.kc        <= 1'b1;
                        2'd2:    upd.strb.kf        <= 1'b1;
                        default: upd.strb.pms_ams   <= 1'b1;
                    endcase
                end else begin
                    upd.slot <= sel_addr[4:0];
                    case (sel_addr[7:5])
                        3'd2:    upd.strb.dt1_mul <= 1'b1;
                        3'd3:    upd.strb.tl      <= 1'b1;
                        3'd4:    upd.strb.ks_ar   <= 1'b1;
                        3'd5:    upd.strb.ams_d1r <= 1'b1;
                        3'd6:    upd.strb.dt2_d2r <= 1'b1;
                        3'd7:    upd.strb.d1l_rr  <= 1'b1;
                        default: ; // Below 0x40, never here
                    endcase
                end
            end
        end
    end

    // Busy window of BUSY_TICKS cen ticks after each new data write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_wr_q <= 1'b0;
            busy      <= 1'b0;
            busy_cnt  <= '0;
        end else begin
            data_wr_q <= data_wr;
            if (data_wr && !data_wr_q) begin
                busy     <= 1'b1;
                busy_cnt <= '0;
            end else if (busy && cen) begin
                busy_cnt <= busy_cnt + 1'b1;
                if (busy_cnt == BUSY_CNT_W'(BUSY_TICKS - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (rst) $onehot0(upd.strb))
        else $error("More than one update strobe active: %b", upd.strb);

endmodule

/* src/fm_slot_regs.sv */
// Every parameter resets to zero and key-on mask bit 3+n drives operator n of the channel
`timescale 1ns/1ns

module fm_slot_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  fm_pkg::upd_t         upd,
    output fm_pkg::slot_t        cur_slot,
    output logic                 zero,
    output fm_pkg::slot_params_t params
);
    import fm_pkg::*;

    typedef struct packed {
        logic [1:0] rl;
        logic [2:0] fb;
        logic [2:0] con;
        logic [6:0] kc;
        logic [5:0] kf;
        logic [2:0] pms;
        logic [1:0] ams;
    } ch_regs_t;

    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic       amsen;
        logic [4:0] d1r;
        logic [1:0] dt2;
        logic [4:0] d2r;
        logic [3:0] d1l;
        logic [3:0] rr;
    } op_regs_t;

    ch_regs_t             ch_mem [NUM_CH];
    op_regs_t             op_mem [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] keyon_vec;
    ch_t                  wr_ch;   // Channel of the pending update
    ch_t                  cur_ch;

    assign wr_ch  = upd.slot[2:0];
    assign cur_ch = cur_slot[2:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                ch_mem[i] <= '0;
            end
            for (int i = 0; i < NUM_SLOTS; i++) begin
                op_mem[i] <= '0;
            end
            keyon_vec <= '0;
        end else begin
            if (upd.strb.rl_fb_con) begin
                ch_mem[wr_ch].rl  <= upd.data[7:6];
                ch_mem[wr_ch].fb  <= upd.data[5:3];
                ch_mem[wr_ch].con <= upd.data[2:0];
            end
            if (upd.strb.kc) ch_mem[wr_ch].kc <= upd.data[6:0];
            if (upd.strb.kf) ch_mem[wr_ch].kf <= upd.data[7:2];
            if (upd.strb.pms_ams) begin
                ch_mem[wr_ch].pms <= upd.data[6:4];
                ch_mem[wr_ch].ams <= upd.data[1:0];
            end

            // Operator fields, indexed by the full slot
            if (upd.strb.dt1_mul) begin
                op_mem[upd.slot].dt1 <= upd.data[6:4];
                op_mem[upd.slot].mul <= upd.data[3:0];
            end
            if (upd.strb.tl) op_mem[upd.slot].tl <= upd.data[6:0];
            if (upd.strb.ks_ar) begin
                op_mem[upd.slot].ks <= upd.data[7:6];
                op_mem[upd.slot].ar <= upd.data[4:0];
            end
            if (upd.strb.ams_d1r) begin
                op_mem[upd.slot].amsen <= upd.data[7];
                op_mem[upd.slot].d1r   <= upd.data[4:0];
            end
            if (upd.strb.dt2_d2r) begin
                op_mem[upd.slot].dt2 <= upd.data[7:6];
                op_mem[upd.slot].d2r <= upd.data[4:0];
            end
            if (upd.strb.d1l_rr) begin
                op_mem[upd.slot].d1l <= upd.data[7:4];
                op_mem[upd.slot].rr  <= upd.data[3:0];
            end

            // All four operators of the channel in one write
            if (upd.strb.keyon) begin
                for (int i = 0; i < 4; i++) begin
                    keyon_vec[{op_t'(i), wr_ch}] <= upd.data[3 + i];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_slot <= '0;
        end else if (cen) begin
            cur_slot <= cur_slot + 1'b1; // Wraps 31 to 0
        end
    end

    assign zero = (cur_slot == '0);

    // Current slot straight from storage
    always_comb begin
        params.rl    = ch_mem[cur_ch].rl;
        params.fb    = ch_mem[cur_ch].fb;
        params.con   = ch_mem[cur_ch].con;
        params.kc    = ch_mem[cur_ch].kc;
        params.kf    = ch_mem[cur_ch].kf;
        params.pms   = ch_mem[cur_ch].pms;
        params.ams   = ch_mem[cur_ch].ams;
        params.dt1   = op_mem[cur_slot].dt1;
        params.mul   = op_mem[cur_slot].mul;
        params.tl    = op_mem[cur_slot].tl;
        params.ks    = op_mem[cur_slot].ks;
        params.ar    = op_mem[cur_slot].ar;
        params.amsen = op_mem[cur_slot].amsen;
        params.d1r   = op_mem[cur_slot].d1r;
        params.dt2   = op_mem[cur_slot].dt2;
        params.d2r   = op_mem[cur_slot].d2r;
        params.d1l   = op_mem[cur_slot].d1l;
        params.rr    = op_mem[cur_slot].rr;
        params.keyon = keyon_vec[cur_slot];
    end

    a_slot_step: assert property (@(posedge clk) disable iff (rst)
        cen |=> cur_slot == slot_t'($past(cur_slot) + 1'b1))
        else $error("Slot counter skipped: %0d", cur_slot);

endmodule

/* src/fm_timers.sv */
// A loaded timer keeps running until reset and a flag only sets while its interrupt is enabled
`timescale 1ns/1ns

module fm_timers (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  fm_pkg::timer_ctl_t tctl,
    output logic               flag_a,
    output logic               flag_b,
    output logic               irq_n,
    output logic               overflow_a
);
    import fm_pkg::*;

    timer_a_t                 cnt_a;
    timer_b_t                 cnt_b;
    logic [TIMER_B_PRE_W-1:0] pre_b;   // cen ticks within one timer B count
    logic                     run_a;
    logic                     run_b;
    logic                     tick_b;
    logic                     overflow_b;

    assign overflow_a = run_a & cen & (cnt_a == '1);
    assign tick_b     = run_b & cen & (pre_b == TIMER_B_PRE_W'(TIMER_B_DIV - 1));
    assign overflow_b = tick_b & (cnt_b == '1);
    assign irq_n      = ~(flag_a | flag_b);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_a <= '0;
            run_a <= 1'b0;
        end else if (tctl.load_a) begin
            cnt_a <= tctl.value_a;
            run_a <= 1'b1;
        end else if (overflow_a) begin
            cnt_a <= tctl.value_a; // Reload past 1023
        end else if (run_a && cen) begin
            cnt_a <= cnt_a + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_b <= '0;
            pre_b <= '0;
            run_b <= 1'b0;
        end else if (tctl.load_b) begin
            cnt_b <= tctl.value_b;
            pre_b <= '0;
            run_b <= 1'b1;
        end else if (run_b && cen) begin
            pre_b <= tick_b ? '0 : pre_b + 1'b1;
            if (overflow_b) begin
                cnt_b <= tctl.value_b;
            end else if (tick_b) begin
                cnt_b <= cnt_b + 1'b1;
            end
        end
    end

    // Overflow takes priority over a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (overflow_a && tctl.irq_en_a) begin
                flag_a <= 1'b1;
            end else if (tctl.clr_flag_a) begin
                flag_a <= 1'b0;
            end
            if (overflow_b && tctl.irq_en_b) begin
                flag_b <= 1'b1;
            end else if (tctl.clr_flag_b) begin
                flag_b <= 1'b0;
            end
        end
    end

    a_flag_a_src: assert property (@(posedge clk) disable iff (rst)
        $rose(flag_a) |-> $past(overflow_a))
        else $error("flag_a rose without a timer A overflow");

    a_flag_b_src: assert property (@(posedge clk) disable iff (rst)
        $rose(flag_b) |-> $past(overflow_b))
        else $error("flag_b rose without a timer B overflow");

endmodule

/* src/fm_regif_top.sv */
// Register interface only with no sound generation and timer A overflow left for a CSM user
`timescale 1ns/1ns

module fm_regif_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  logic                 write,
    input  logic                 a0,
    input  fm_pkg::reg_data_t    din,
    output logic                 busy,
    output logic                 lfo_rst,
    output logic                 zero,
    output logic                 flag_a,
    output logic                 flag_b,
    output logic                 irq_n,
    output fm_pkg::global_cfg_t  gcfg,
    output fm_pkg::slot_t        cur_slot,
    output fm_pkg::slot_params_t params
);
    import fm_pkg::*;

    upd_t       upd;   // Host write decoded for slot storage
    timer_ctl_t tctl;

    fm_mmr u_mmr (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .din     (din),
        .write   (write),
        .a0      (a0),
        .busy    (busy),
        .upd     (upd),
        .gcfg    (gcfg),
        .tctl    (tctl),
        .lfo_rst (lfo_rst)
    );

    fm_slot_regs u_slot_regs (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .upd      (upd),
        .cur_slot (cur_slot),
        .zero     (zero),
        .params   (params)
    );

    fm_timers u_timers (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .tctl       (tctl),
        .flag_a     (flag_a),
        .flag_b     (flag_b),
        .irq_n      (irq_n),
        .overflow_a ()      // Would trigger CSM key-on
    );

endmodule

/* dv/fm_regif_tb.sv */
// Run from the project root so the stimulus file opens, and each host write waits for busy to fall
`timescale 1ns/1ns

module fm_regif_tb;
    import fm_pkg::*;

    localparam int    CLK_PERIOD   = 100;
    localparam int    CEN_PER_LINE = 40;  // Watchdog allowance per stimulus line
    localparam int    VAL_W        = 72;  // Wide enough for a whole slot_params_t
    localparam string STIM_FILE    = "dv/fm_regif_stimulus.txt";

    typedef logic [VAL_W-1:0] val_t;

    logic         clk;
    logic         rst;
    logic         cen;
    logic         write;
    logic         a0;
    reg_data_t    din;
    logic         busy;
    logic         lfo_rst;
    logic         zero;
    logic         flag_a;
    logic         flag_b;
    logic         irq_n;
    global_cfg_t  gcfg;
    slot_t        cur_slot;
    slot_params_t params;

    int    cen_budget;
    int    tests;
    int    checks;
    int    errors;
    int    test_checks;
    int    test_errors;
    string test_name;

    fm_regif_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .write    (write),
        .a0       (a0),
        .din      (din),
        .busy     (busy),
        .lfo_rst  (lfo_rst),
        .zero     (zero),
        .flag_a   (flag_a),
        .flag_b   (flag_b),
        .irq_n    (irq_n),
        .gcfg     (gcfg),
        .cur_slot (cur_slot),
        .params   (params)
    );

    // Clock, with cen toggling on each falling edge
    initial begin
        clk = 1'b0;
        cen = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
            if (!clk) begin
                cen = ~cen; // Half rate pipeline enable
            end
        end
    end

    task automatic check_value(input string name, input val_t got, input val_t exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("mismatch %s: got %0h, expected %0h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            tests++;
            if (test_errors == 0) begin
                $display("test %s: passed, %0d checks", test_name, test_checks);
            end else begin
                $display("test %s: failed, %0d errors in %0d checks", test_name, test_errors,
                         test_checks);
            end
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != "\n" && c != -1) c = $fgetc(fd);
    endtask

    // Line count and timer spans give the watchdog limit
    task automatic measure_run(output int budget);
        int        fd;
        string     tok;
        string     tmr;
        reg_data_t ctl;
        int        span;
        budget = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                budget += CEN_PER_LINE;
                if (tok == "T" && $fscanf(fd, "%s %h %d", tmr, ctl, span) == 3) begin
                    budget += span;
                end
                skip_line(fd);
            end
            $fclose(fd);
        end
    endtask

    function automatic val_t global_field(input string f, output bit ok);
        ok = 1'b1;
        case (f)
            "ne":       return gcfg.ne;
            "nfrq":     return gcfg.nfrq;
            "lfo_freq": return gcfg.lfo_freq;
            "lfo_w":    return gcfg.lfo_w;
            "lfo_amd":  return gcfg.lfo_amd;
            "lfo_pmd":  return gcfg.lfo_pmd;
            "ct1":      return gcfg.ct1;
            "ct2":      return gcfg.ct2;
            "busy":     return busy;
            "irq_n":    return irq_n;
            "flag_a":   return flag_a;
            "flag_b":   return flag_b;
            default: begin
                ok = 1'b0;
                return '0;
            end
        endcase
    endfunction

    function automatic val_t param_field(input string f, input slot_params_t p, output bit ok);
        ok = 1'b1;
        case (f)
            "all":   return val_t'(p);
            "rl":    return p.rl;
            "fb":    return p.fb;
            "con":   return p.con;
            "kc":    return p.kc;
            "kf":    return p.kf;
            "pms":   return p.pms;
            "ams":   return p.ams;
            "dt1":   return p.dt1;
            "mul":   return p.mul;
            "tl":    return p.tl;
            "ks":    return p.ks;
            "ar":    return p.ar;
            "amsen": return p.amsen;
            "d1r":   return p.d1r;
            "dt2":   return p.dt2;
            "d2r":   return p.d2r;
            "d1l":   return p.d1l;
            "rr":    return p.rr;
            "keyon": return p.keyon;
            default: begin
                ok = 1'b0;
                return '0;
            end
        endcase
    endfunction

    // Address then data, both entered on falling edges
    task automatic host_write(input reg_addr_t addr, input reg_data_t data);
        int ticks;
        write = 1'b1;
        a0    = 1'b0;
        din   = addr;
        @(negedge clk);
        write = 1'b0;
        @(negedge clk);
        check_value("busy after address write", busy, 0);
        write = 1'b1;
        a0    = 1'b1;
        din   = data;
        @(negedge clk);
        write = 1'b0;
        a0    = 1'b0;
        check_value("busy after data write", busy, 1);
        check_value("lfo_rst after data write", lfo_rst, addr == REG_LFRQ); // LFO rate only
        ticks = 0;
        while (busy) begin
            @(posedge clk);
            if (cen) ticks++;
            @(negedge clk);
        end
        check_value("busy length in cen ticks", ticks, BUSY_TICKS);
        check_value("lfo_rst after busy", lfo_rst, 0);
    endtask

    // Slot ff walks all 32 slots in order
    task automatic check_slots(input logic [7:0] sel, input string f, input val_t exp);
        int   first;
        int   last;
        bit   ok;
        val_t got;
        first = (sel == 8'hff) ? 0 : int'(sel);
        last  = (sel == 8'hff) ? NUM_SLOTS - 1 : int'(sel);
        for (int s = first; s <= last; s++) begin
            while (cur_slot != slot_t'(s)) @(negedge clk);
            got = param_field(f, params, ok);
            if (!ok) begin
                note_failure({"unknown slot field ", f});
                return;
            end
            check_value($sformatf("params.%s at slot %0d", f, s), got, exp);
            check_value($sformatf("zero at slot %0d", s), zero, s == 0);
        end
    endtask

    function automatic logic timer_flag(input string which);
        return (which == "A") ? flag_a : flag_b;
    endfunction

    // Timer control write without the busy wait, then count cen ticks to the flag
    task automatic run_timer(input string which, input reg_data_t ctl, input int span);
        int ticks;
        write = 1'b1;
        a0    = 1'b0;
        din   = REG_TIMER;
        @(negedge clk);
        a0  = 1'b1;
        din = ctl;
        @(negedge clk);
        write = 1'b0;
        a0    = 1'b0;
        ticks = 0;
        while (!timer_flag(which) && ticks < span) begin
            @(posedge clk);
            if (cen) ticks++;
            @(negedge clk);
        end
        if (!timer_flag(which)) begin
            note_failure($sformatf("flag_%s did not rise within %0d cen ticks", which, span));
        end else begin
            check_value("irq_n with a flag set", irq_n, 0);
        end
        while (busy) @(negedge clk);
    endtask

    task automatic run_stimulus(input int fd);
        string      cmd;
        string      field;
        string      tmr;
        reg_addr_t  addr;
        reg_data_t  data;
        logic [7:0] slot_sel;
        val_t       exp_v;
        val_t       got;
        bit         ok;
        int         span;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "N": begin
                    finish_test();
                    if ($fscanf(fd, "%s", test_name) != 1) note_failure("test name missing");
                end
                "W": begin
                    if ($fscanf(fd, "%h %h", addr, data) != 2) begin
                        note_failure("malformed write line in stimulus");
                    end else begin
                        host_write(addr, data);
                    end
                end
                "S": begin
                    if ($fscanf(fd, "%h %s %h", slot_sel, field, exp_v) != 3) begin
                        note_failure("malformed slot check line in stimulus");
                    end else begin
                        check_slots(slot_sel, field, exp_v);
                    end
                end
                "G": begin
                    if ($fscanf(fd, "%s %h", field, exp_v) != 2) begin
                        note_failure("malformed global check line in stimulus");
                    end else begin
                        got = global_field(field, ok);
                        if (ok) begin
                            check_value(field, got, exp_v);
                        end else begin
                            note_failure({"unknown global field ", field});
                        end
                    end
                end
                "T": begin
                    if ($fscanf(fd, "%s %h %d", tmr, data, span) != 3) begin
                        note_failure("malformed timer line in stimulus");
                    end else begin
                        run_timer(tmr, data, span);
                    end
                end
                default: begin
                    if (cmd[0] != "#") note_failure({"unknown stimulus command ", cmd});
                    skip_line(fd);
                end
            endcase
        end
    endtask

    initial begin
        int fd;
        rst        = 1'b1;
        write      = 1'b0;
        a0         = 1'b0;
        din        = '0;
        test_name  = "";
        measure_run(cen_budget);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fd  = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            note_failure({"cannot open the stimulus file ", STIM_FILE});
        end else begin
            run_stimulus(fd);
            $fclose(fd);
        end
        finish_test();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (cen_budget > 0);
        repeat (cen_budget) @(posedge cen);
        $display("timeout: stimulus not finished after %0d cen ticks", cen_budget);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* dv/fm_regif_stimulus.txt */
# N name | W addr data | S slot field value | G field value | T timer ctl span
# Hex except the T span in cen ticks, slot ff checks every slot
N reset
G busy 0
G irq_n 1
G flag_a 0
G flag_b 0
S ff all 0
N global
W 0f 95
G nfrq 15
W 18 c3
G lfo_freq c3
W 19 2a
W 19 b1
G lfo_amd 2a
G lfo_pmd 31
W 1b c2
G lfo_w 2
G ct2 1
N channel
W 25 d3
S 05 fb 2
S 0d con 3
S 1d rl 3
S 04 con 0
N operator
W 6d 7f
S 0d tl 7f
S 0c tl 0
N keyon
W 08 53
S 03 keyon 0
S 0b keyon 1
S 13 keyon 0
S 1b keyon 1
N timer_a
W 10 ff
W 11 00
T A 05 8
G flag_a 1
W 14 10
G flag_a 0
G irq_n 1

/* compile.f */
src/fm_pkg.sv
src/fm_mmr.sv
src/fm_slot_regs.sv
src/fm_timers.sv
src/fm_regif_top.sv
dv/fm_regif_tb.sv
